//--- design/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// data word width
`define XLEN 16

// r0 reads zero and is never renamed
`define ARCH_REGS 16

// prn 0 is the constant zero
`define PHYS_REGS 32

`define ROB_SZ 8
`define RS_SZ 4

`endif

//--- design/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arn_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] prn_t;
    typedef logic [$clog2(`ROB_SZ)-1:0]    robn_t;
    typedef logic [`XLEN-1:0]              data_t;

    // any other encoding is illegal
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        ADDI = 4'h5,
        LI   = 4'h6
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        arn_t    rd;
        arn_t    rs1;
        arn_t    rs2;
    } r_fmt_t;

    // ADDI still takes rs1 from bits 7:4
    typedef struct packed {
        alu_op_e    op;
        arn_t       rd;
        logic [7:0] imm8;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_t;

endpackage

//--- design/dispatch_ctrl.sv
`include "ooo_macros.svh"

module dispatch_ctrl import ooo_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  logic    inst_valid,
    input  inst_t   inst,
    input  logic    rob_full,
    input  logic    rs_full,
    input  logic    squash,
    input  robn_t   rob_tail,
    input  logic    retire,
    input  arn_t    retire_arn_in,
    input  logic    retire_exc_in,
    input  data_t   retire_data,
    output logic    stall,
    output logic    dispatch,
    output alu_op_e op,
    output data_t   imm,
    output arn_t    src1_arn,
    output arn_t    src2_arn,
    output arn_t    dest_arn,
    output logic    illegal,
    output logic    retire_valid,
    output arn_t    retire_arn,
    output data_t   retire_value,
    output logic    retire_exception
);

    assign stall    = rob_full || rs_full || squash;
    assign dispatch = inst_valid && !stall;

    // op and rd sit at the same bits in both views
    assign op  = inst.r_fmt.op;
    assign imm = {{(`XLEN-8){inst.i_fmt.imm8[7]}}, inst.i_fmt.imm8};

    always_comb begin
        src1_arn = inst.r_fmt.rs1;
        src2_arn = inst.r_fmt.rs2;
        dest_arn = inst.r_fmt.rd;
        illegal  = !(op inside {ADD, SUB, AND, OR, XOR, ADDI, LI});
        if (op == ADDI || op == LI || illegal) begin
            src2_arn = '0;
        end
        if (op == LI || illegal) begin
            src1_arn = '0;
        end
        // an illegal word renames nothing
        if (illegal) begin
            dest_arn = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            retire_valid     <= 1'b0;
            retire_exception <= 1'b0;
        end else begin
            retire_valid     <= retire;
            retire_exception <= retire_exc_in;
        end
    end

    // sampled on the retire edge before the prn is reused
    always_ff @(posedge clock) begin
        retire_arn   <= retire_arn_in;
        retire_value <= retire_exc_in ? '0 : retire_data;
    end

    // each dispatch takes exactly one rob slot
    assert property (@(posedge clock) disable iff (rst)
        dispatch |=> rob_tail == $past(rob_tail) + 1'b1);

endmodule

//--- design/rat.sv
`include "ooo_macros.svh"

module rat import ooo_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  logic dispatch,
    input  arn_t src1_arn,
    input  arn_t src2_arn,
    input  arn_t dest_arn,
    input  logic retire,
    input  arn_t retire_arn,
    input  prn_t retire_prn,
    input  prn_t retire_old_prn,
    input  logic squash,
    output prn_t src1_prn,
    output prn_t src2_prn,
    output prn_t dest_prn,
    output prn_t old_prn
);

    localparam int FL_SZ = `PHYS_REGS - `ARCH_REGS;
    localparam int FW    = $clog2(FL_SZ);

    prn_t map [`ARCH_REGS];
    prn_t ret_map [`ARCH_REGS];
    prn_t free_list [FL_SZ];

    // pointers carry a wrap bit so full and empty differ
    logic [FW:0] head;
    logic [FW:0] ret_head;
    logic [FW:0] fl_tail;
    logic [FW:0] ret_head_next;

    assign src1_prn = map[src1_arn];
    assign src2_prn = map[src2_arn];
    assign dest_prn = free_list[head[FW-1:0]];

    // every dispatch pops, r0 hands its own prn back at retire
    assign old_prn = (dest_arn == '0) ? dest_prn : map[dest_arn];

    assign ret_head_next = retire ? ret_head + 1'b1 : ret_head;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i]     <= prn_t'(i);
                ret_map[i] <= prn_t'(i);
            end
            for (int i = 0; i < FL_SZ; i++) begin
                free_list[i] <= prn_t'(`ARCH_REGS + i);
            end
            head     <= '0;
            ret_head <= '0;
            fl_tail  <= {1'b1, {FW{1'b0}}};
        end else begin
            if (retire) begin
                free_list[fl_tail[FW-1:0]] <= retire_old_prn;
                fl_tail  <= fl_tail + 1'b1;
                ret_head <= ret_head_next;
                if (retire_arn != '0) begin
                    ret_map[retire_arn] <= retire_prn;
                end
            end
            if (squash) begin
                head <= ret_head_next;
                // the squashing entry is illegal and maps no arn
                for (int i = 0; i < `ARCH_REGS; i++) begin
                    map[i] <= ret_map[i];
                end
            end else if (dispatch) begin
                head <= head + 1'b1;
                if (dest_arn != '0) begin
                    map[dest_arn] <= dest_prn;
                end
            end
        end
    end

    // rob depth keeps the free list from running dry
    assert property (@(posedge clock) disable iff (rst)
        dispatch |-> head != fl_tail);

endmodule

//--- design/prf.sv
`include "ooo_macros.svh"

module prf import ooo_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  prn_t  rd1_prn,
    input  prn_t  rd2_prn,
    input  logic  alloc,
    input  prn_t  alloc_prn,
    input  logic  cdb_valid,
    input  prn_t  cdb_prn,
    input  data_t cdb_value,
    input  prn_t  ret_prn,
    output data_t rd1_value,
    output logic  rd1_ready,
    output data_t rd2_value,
    output logic  rd2_ready,
    output data_t ret_value
);

    data_t                 values [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;

    function automatic logic rd_ready(prn_t prn);
        return prn == '0 || ready[prn] || (cdb_valid && cdb_prn == prn);
    endfunction

    // not ready yet, so hand out the prn as the wakeup tag
    function automatic data_t rd_value(prn_t prn);
        if (prn == '0) begin
            return '0;
        end
        if (cdb_valid && cdb_prn == prn) begin
            return cdb_value;
        end
        return ready[prn] ? values[prn] : data_t'(prn);
    endfunction

    always_comb begin
        rd1_ready = rd_ready(rd1_prn);
        rd1_value = rd_value(rd1_prn);
        rd2_ready = rd_ready(rd2_prn);
        rd2_value = rd_value(rd2_prn);
    end

    assign ret_value = values[ret_prn];

    always_ff @(posedge clock) begin
        if (rst) begin
            ready <= '1;
            for (int i = 0; i < `PHYS_REGS; i++) begin
                values[i] <= '0;
            end
        end else begin
            if (alloc) begin
                ready[alloc_prn] <= 1'b0;
            end
            if (cdb_valid) begin
                ready[cdb_prn]  <= 1'b1;
                values[cdb_prn] <= cdb_value;
            end
        end
    end

endmodule

//--- design/rob.sv
`include "ooo_macros.svh"

module rob import ooo_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  dispatch,
    input  arn_t  dest_arn,
    input  prn_t  dest_prn,
    input  prn_t  old_prn,
    input  logic  illegal,
    input  logic  cdb_valid,
    input  robn_t cdb_robn,
    output robn_t tail,
    output logic  full,
    output logic  retire,
    output arn_t  retire_arn,
    output prn_t  retire_prn,
    output prn_t  retire_old_prn,
    output logic  retire_exc,
    output logic  squash
);

    localparam int CW = $clog2(`ROB_SZ) + 1;

    arn_t              arn_q [`ROB_SZ];
    prn_t              prn_q [`ROB_SZ];
    prn_t              old_q [`ROB_SZ];
    logic [`ROB_SZ-1:0] exc_q;
    logic [`ROB_SZ-1:0] done;
    robn_t             head;
    logic [CW-1:0]     count;

    assign full   = count == CW'(`ROB_SZ);
    assign retire = count != '0 && done[head];
    assign squash = retire && exc_q[head];

    assign retire_arn     = arn_q[head];
    assign retire_prn     = prn_q[head];
    assign retire_old_prn = old_q[head];
    assign retire_exc     = exc_q[head];

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            // illegal words need no execution
            if (dispatch) begin
                done[tail] <= illegal;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_robn] <= 1'b1;
            end
            if (retire) begin
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({dispatch, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch) begin
            arn_q[tail] <= dest_arn;
            prn_q[tail] <= dest_prn;
            old_q[tail] <= old_prn;
            exc_q[tail] <= illegal;
        end
    end

    assert property (@(posedge clock) disable iff (rst)
        dispatch |-> !full);

endmodule

//--- design/rs.sv
`include "ooo_macros.svh"

module rs import ooo_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  logic    squash,
    input  logic    dispatch,
    input  alu_op_e op,
    input  data_t   imm,
    input  data_t   op1,
    input  logic    op1_ready,
    input  data_t   op2,
    input  logic    op2_ready,
    input  prn_t    dest_prn,
    input  robn_t   robn,
    input  logic    cdb_valid,
    input  prn_t    cdb_prn,
    input  data_t   cdb_value,
    output logic    full,
    output logic    issue_valid,
    output alu_op_e issue_op,
    output data_t   issue_a,
    output data_t   issue_b,
    output data_t   issue_imm,
    output prn_t    issue_prn,
    output robn_t   issue_robn
);

    localparam int AW = $clog2(`RS_SZ);
    localparam int PW = $bits(prn_t);

    logic [`RS_SZ-1:0] valid;
    // number of younger entries still present
    logic [AW-1:0]     age [`RS_SZ];
    alu_op_e           op_q [`RS_SZ];
    data_t             imm_q [`RS_SZ];
    prn_t              prn_q [`RS_SZ];
    robn_t             robn_q [`RS_SZ];
    // a waiting operand holds its prn as the tag
    data_t             opnd [`RS_SZ][2];
    logic [1:0]        rdy [`RS_SZ];
    logic [AW-1:0]     sel;
    logic [AW-1:0]     slot;

    assign full = &valid;

    // oldest ready entry
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (valid[i] && &rdy[i] && (!issue_valid || age[i] > age[sel])) begin
                issue_valid = 1'b1;
                sel         = AW'(i);
            end
        end
    end

    always_comb begin
        slot = '0;
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                slot = AW'(i);
            end
        end
    end

    assign issue_op   = op_q[sel];
    assign issue_a    = opnd[sel][0];
    assign issue_b    = opnd[sel][1];
    assign issue_imm  = imm_q[sel];
    assign issue_prn  = prn_q[sel];
    assign issue_robn = robn_q[sel];

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < `RS_SZ; i++) begin
                if (valid[i]) begin
                    age[i] <= age[i] + AW'(dispatch)
                              - AW'(issue_valid && age[i] > age[sel]);
                end
            end
            if (issue_valid) begin
                valid[sel] <= 1'b0;
            end
            if (dispatch) begin
                valid[slot] <= 1'b1;
                age[slot]   <= '0;
            end
        end
    end

    // wakeup, then capture of a new entry
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SZ; i++) begin
            for (int j = 0; j < 2; j++) begin
                if (cdb_valid && !rdy[i][j] && opnd[i][j][PW-1:0] == cdb_prn) begin
                    opnd[i][j] <= cdb_value;
                    rdy[i][j]  <= 1'b1;
                end
            end
        end
        if (dispatch) begin
            op_q[slot]    <= op;
            imm_q[slot]   <= imm;
            prn_q[slot]   <= dest_prn;
            robn_q[slot]  <= robn;
            opnd[slot][0] <= op1;
            opnd[slot][1] <= op2;
            rdy[slot]     <= {op2_ready, op1_ready};
        end
    end

endmodule

//--- design/alu_fu.sv
module alu_fu import ooo_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  logic    squash,
    input  logic    issue_valid,
    input  alu_op_e issue_op,
    input  data_t   issue_a,
    input  data_t   issue_b,
    input  data_t   issue_imm,
    input  prn_t    issue_prn,
    input  robn_t   issue_robn,
    output logic    cdb_valid,
    output prn_t    cdb_prn,
    output data_t   cdb_value,
    output robn_t   cdb_robn
);

    data_t result;
    logic  s1_valid;
    data_t s1_result;
    prn_t  s1_prn;
    robn_t s1_robn;

    // wraps at the word width
    always_comb begin
        case (issue_op)
            ADD:     result = issue_a + issue_b;
            SUB:     result = issue_a - issue_b;
            AND:     result = issue_a & issue_b;
            OR:      result = issue_a | issue_b;
            XOR:     result = issue_a ^ issue_b;
            ADDI:    result = issue_a + issue_imm;
            LI:      result = issue_imm;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            s1_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_result <= result;
        s1_prn    <= issue_prn;
        s1_robn   <= issue_robn;
        cdb_value <= s1_result;
        cdb_prn   <= s1_prn;
        cdb_robn  <= s1_robn;
    end

endmodule

//--- design/ooo.sv
module ooo import ooo_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  inst_valid,
    input  inst_t inst,
    output logic  stall,
    output logic  retire_valid,
    output arn_t  retire_arn,
    output data_t retire_value,
    output logic  retire_exception,
    output logic  squash
);

    logic    dispatch;
    logic    illegal;
    alu_op_e op;
    data_t   imm;
    arn_t    src1_arn;
    arn_t    src2_arn;
    arn_t    dest_arn;
    prn_t    src1_prn;
    prn_t    src2_prn;
    prn_t    dest_prn;
    prn_t    old_prn;
    data_t   op1;
    data_t   op2;
    logic    op1_ready;
    logic    op2_ready;
    logic    rob_full;
    logic    rs_full;
    robn_t   rob_tail;
    logic    retire;
    arn_t    ret_arn;
    prn_t    ret_prn;
    prn_t    ret_old_prn;
    logic    ret_exc;
    data_t   ret_value;
    logic    issue_valid;
    alu_op_e issue_op;
    data_t   issue_a;
    data_t   issue_b;
    data_t   issue_imm;
    prn_t    issue_prn;
    robn_t   issue_robn;
    logic    cdb_valid;
    prn_t    cdb_prn;
    data_t   cdb_value;
    robn_t   cdb_robn;

    dispatch_ctrl dispatch_ctrl_i (
        .clock, .rst, .inst_valid, .inst, .rob_full, .rs_full, .squash, .rob_tail,
        .retire, .retire_arn_in(ret_arn), .retire_exc_in(ret_exc), .retire_data(ret_value),
        .stall, .dispatch, .op, .imm, .src1_arn, .src2_arn, .dest_arn, .illegal,
        .retire_valid, .retire_arn, .retire_value, .retire_exception
    );

    rat rat_i (
        .clock, .rst, .dispatch, .src1_arn, .src2_arn, .dest_arn,
        .retire, .retire_arn(ret_arn), .retire_prn(ret_prn), .retire_old_prn(ret_old_prn),
        .squash, .src1_prn, .src2_prn, .dest_prn, .old_prn
    );

    prf prf_i (
        .clock, .rst, .rd1_prn(src1_prn), .rd2_prn(src2_prn),
        .alloc(dispatch), .alloc_prn(dest_prn), .cdb_valid, .cdb_prn, .cdb_value,
        .ret_prn, .rd1_value(op1), .rd1_ready(op1_ready),
        .rd2_value(op2), .rd2_ready(op2_ready), .ret_value
    );

    rob rob_i (
        .clock, .rst, .dispatch, .dest_arn, .dest_prn, .old_prn, .illegal,
        .cdb_valid, .cdb_robn, .tail(rob_tail), .full(rob_full), .retire,
        .retire_arn(ret_arn), .retire_prn(ret_prn), .retire_old_prn(ret_old_prn),
        .retire_exc(ret_exc), .squash
    );

    // illegal words go straight to the rob
    rs rs_i (
        .clock, .rst, .squash, .dispatch(dispatch && !illegal), .op, .imm,
        .op1, .op1_ready, .op2, .op2_ready, .dest_prn, .robn(rob_tail),
        .cdb_valid, .cdb_prn, .cdb_value, .full(rs_full), .issue_valid, .issue_op,
        .issue_a, .issue_b, .issue_imm, .issue_prn, .issue_robn
    );

    alu_fu alu_fu_i (
        .clock, .rst, .squash, .issue_valid, .issue_op, .issue_a, .issue_b,
        .issue_imm, .issue_prn, .issue_robn, .cdb_valid, .cdb_prn, .cdb_value, .cdb_robn
    );

endmodule

//--- dv/ooo_tb.sv
module ooo_tb
    import ooo_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CHAIN   = 60;
    localparam int N_MIX     = 300;
    localparam int N_BURST   = 4;
    localparam int BURST_LEN = 20;
    localparam int N_SQUASH  = 300;
    localparam int N_INSTS   = 16 + N_CHAIN + N_MIX + N_BURST * BURST_LEN + N_SQUASH;
    localparam int WATCHDOG_CYCLES = 40 * N_INSTS + 500;

    logic        clock;
    logic        rst;
    logic        inst_valid;
    logic [15:0] inst;
    logic        stall;
    logic        retire_valid;
    arn_t        retire_arn;
    data_t       retire_value;
    logic        retire_exception;
    logic        squash;

    // architectural state and expected retire records {exc, arn, value}
    logic [15:0] regs [16];
    logic [20:0] exp_q [$];
    logic        in_shadow;
    logic        prev_squash;
    int          err_count;
    int          start_errs;
    int          pass_count;
    int          fail_count;
    int          stall_cycles;
    string       test_name;

    ooo dut_i (
        .clock, .rst, .inst_valid, .inst, .stall, .retire_valid, .retire_arn,
        .retire_value, .retire_exception, .squash
    );

    always #2 clock = ~clock;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
        end
    endtask

    function automatic logic [15:0] sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    // program order model, run at acceptance
    task automatic record(input logic [15:0] word);
        logic [3:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] result;
        logic        exc;
        if (in_shadow) begin
            return;
        end
        rd  = word[11:8];
        a   = regs[word[7:4]];
        b   = regs[word[3:0]];
        exc = 1'b0;
        case (word[15:12])
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            ADDI:    result = a + sext8(word[7:0]);
            LI:      result = sext8(word[7:0]);
            default: begin
                result = '0;
                exc    = 1'b1;
            end
        endcase
        if (exc) begin
            in_shadow = 1'b1;
            exp_q.push_back({1'b1, 4'h0, 16'h0});
        end else begin
            if (rd != 4'h0) begin
                regs[rd] = result;
            end
            exp_q.push_back({1'b0, rd, result});
        end
    endtask

    // word is held until the core takes it
    task automatic send(input logic [15:0] word);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            inst_valid = 1'b1;
            inst       = word;
            #1;
            if (squash) begin
                in_shadow = 1'b0;
            end
            if (stall) begin
                stall_cycles++;
            end else begin
                accepted = 1'b1;
            end
        end
        record(word);
    endtask

    task automatic drain();
        int idle;
        idle = 0;
        @(negedge clock);
        inst_valid = 1'b0;
        while (idle < 12) begin
            @(negedge clock);
            #1;
            if (squash) begin
                in_shadow = 1'b0;
            end
            idle = (exp_q.size() == 0) ? idle + 1 : 0;
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_errs   = err_count;
        stall_cycles = 0;
    endtask

    task automatic end_test();
        drain();
        if (err_count == start_errs) begin
            pass_count++;
            $display("test %s: pass", test_name);
        end else begin
            fail_count++;
            $display("test %s: FAIL (%0d errors)", test_name, err_count - start_errs);
        end
    endtask

    function automatic logic [15:0] rand_legal();
        logic [3:0] op;
        op = 4'($urandom_range(0, 6));
        return {op, 4'($urandom_range(0, 15)), 8'($urandom_range(0, 255))};
    endfunction

    // retire outputs are registered, so sample them mid-cycle
    always @(negedge clock) begin
        logic [20:0] rec;
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("%s: an instruction retired that the program never kept", test_name);
            end else begin
                rec = exp_q.pop_front();
                check_value("exception", rec[20], retire_exception);
                check_value("squash", rec[20], prev_squash);
                if (!rec[20]) begin
                    check_value("arn", rec[19:16], retire_arn);
                    check_value("value", rec[15:0], retire_value);
                end
            end
        end
        prev_squash = squash;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: the core stopped retiring before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int slot;
        void'($urandom(32'hc2b8_a539));
        clock       = 1'b0;
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        in_shadow   = 1'b0;
        prev_squash = 1'b0;
        err_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        repeat (3) @(negedge clock);
        rst = 1'b0;
        #1;

        begin_test("reset_state");
        check_value("stall", 0, stall);
        check_value("retire_valid", 0, retire_valid);
        check_value("squash", 0, squash);
        for (int r = 0; r < 16; r++) begin
            send({ADD, 4'(r), 4'(r), 4'h0});
        end
        end_test();

        begin_test("dependent_chain");
        for (int i = 0; i < N_CHAIN; i++) begin
            if ($urandom_range(0, 1) == 0) begin
                send({ADDI, 4'($urandom_range(1, 4)), 4'($urandom_range(1, 4)),
                      4'($urandom_range(0, 15))});
            end else begin
                send({ADD, 4'($urandom_range(1, 4)), 4'($urandom_range(1, 4)),
                      4'($urandom_range(1, 4))});
            end
        end
        end_test();

        begin_test("random_mix");
        for (int i = 0; i < N_MIX; i++) begin
            send(rand_legal());
        end
        end_test();

        // a serial chain on r1 holds the rs while loads pile up behind it in the rob
        begin_test("back_pressure");
        for (int b = 0; b < N_BURST; b++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                if (i % 2 == 0) begin
                    send({ADDI, 4'h1, 4'h1, 4'($urandom_range(0, 15))});
                end else begin
                    send({LI, 4'($urandom_range(2, 15)), 8'($urandom_range(0, 255))});
                end
            end
            @(negedge clock);
            inst_valid = 1'b0;
            repeat (8) @(negedge clock);
        end
        if (stall_cycles == 0) begin
            err_count++;
            $display("%s: stall never rose during the bursts", test_name);
        end
        end_test();

        begin_test("squash_recovery");
        slot = 0;
        for (int i = 0; i < N_SQUASH; i++) begin
            if (i % 40 == 0) begin
                slot = $urandom_range(0, 39);
            end
            if (i % 40 == slot) begin
                send({4'($urandom_range(7, 15)), 12'($urandom_range(0, 4095))});
            end else begin
                send(rand_legal());
            end
        end
        end_test();

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+design
design/ooo_pkg.sv
design/dispatch_ctrl.sv
design/rat.sv
design/prf.sv
design/rob.sv
design/rs.sv
design/alu_fu.sv
design/ooo.sv
dv/ooo_tb.sv
